// ==== design/apb3_mon_cfg.svh ====
`ifndef APB3_MON_CFG_SVH
`define APB3_MON_CFG_SVH

// Observed address and data bus widths
`define APB3_ADDR_W 16
`define APB3_DATA_W 32

// Number of slave select lines on the bus
`define APB3_PSEL_N 4

// Longest legal run of ACCESS cycles with PREADY low
`define APB3_MAX_WAIT 3

// Saturating violation counter width
`define APB3_VIOL_CNT_W 8

// Wait counter must reach APB3_MAX_WAIT + 1 so the timeout fires only once
`define APB3_WAIT_CNT_W $clog2(`APB3_MAX_WAIT + 2)

`endif

// ==== design/apb3_mon_pkg.sv ====
`default_nettype none

`include "apb3_mon_cfg.svh"

package apb3_mon_pkg;

    // One full sample of the observed APB bus
    typedef struct packed {
        logic [`APB3_PSEL_N-1:0] psel;
        logic                    penable;
        logic [`APB3_ADDR_W-1:0] paddr;
        logic                    pwrite;
        logic [`APB3_DATA_W-1:0] pwdata;
        logic                    pready;
        logic [`APB3_DATA_W-1:0] prdata;
        logic                    pslverr;
    } apb_bus_t;

    // Bus phase decoded from any-PSEL and PENABLE
    // ERROR is PENABLE without any PSEL
    typedef enum logic [1:0] {IDLE, SETUP, ACCESS, ERROR} apb_phase_e;

    // Bit positions inside rule_mask_t
    typedef enum logic [2:0] {
        RULE_PENABLE_NO_PSEL,
        RULE_IDLE_TO_ACCESS,
        RULE_SETUP_NOT_ACCESS,
        RULE_SETUP_UNSTABLE,
        RULE_WAIT_UNSTABLE,
        RULE_WAIT_TIMEOUT,
        RULE_SLVERR_UNSAMPLED,
        RULE_MULTI_SEL
    } apb_rule_e;

    // One bit per apb_rule_e entry
    typedef logic [7:0] rule_mask_t;

    // Encoded slave select
    typedef logic [$clog2(`APB3_PSEL_N)-1:0] slave_idx_t;

    // Completed transfer, data is pwdata on writes and prdata on reads
    typedef struct packed {
        slave_idx_t              slave;
        logic [`APB3_ADDR_W-1:0] addr;
        logic                    write;
        logic [`APB3_DATA_W-1:0] data;
        logic                    slverr;
    } apb_xfer_t;

    typedef logic [`APB3_VIOL_CNT_W-1:0] viol_cnt_t;

endpackage

`default_nettype wire

// ==== design/apb_phase_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apb3_mon_cfg.svh"

module apb_phase_tracker (
    input  wire                             pclk,
    input  wire                             presetn,
    input  wire apb3_mon_pkg::apb_bus_t     bus,
    output apb3_mon_pkg::apb_bus_t          cur,
    output apb3_mon_pkg::apb_bus_t          prev,
    output apb3_mon_pkg::apb_phase_e        cur_phase,
    output apb3_mon_pkg::apb_phase_e        prev_phase,
    output logic [`APB3_WAIT_CNT_W-1:0]     wait_cnt
);

    import apb3_mon_pkg::*;

    // Counter stops one past the limit so the checker sees the limit once
    localparam int WAIT_SAT = `APB3_MAX_WAIT + 1;

    // Phase decode of one sample
    function automatic apb_phase_e classify(input apb_bus_t s);
        apb_phase_e ph;
        case ({|s.psel, s.penable})
            2'b00:   ph = IDLE;
            2'b10:   ph = SETUP;
            2'b11:   ph = ACCESS;
            default: ph = ERROR;
        endcase
        return ph;
    endfunction

    // Bus sampled at edge k, previous sample from edge k-1
    // All zeros after reset reads as IDLE
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            cur  <= '0;
            prev <= '0;
        end else begin
            cur  <= bus;
            prev <= cur;
        end
    end

    // Consecutive ACCESS cycles with PREADY low up to but not including cur
    // Cleared on completion or when the bus leaves ACCESS
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            wait_cnt <= '0;
        end else if (cur_phase == ACCESS && !cur.pready) begin
            if (wait_cnt != WAIT_SAT) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end else begin
            wait_cnt <= '0;
        end
    end

    assign cur_phase  = classify(cur);
    assign prev_phase = classify(prev);

endmodule

`default_nettype wire

// ==== design/apb_rule_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apb3_mon_cfg.svh"

module apb_rule_checker (
    input  wire                             pclk,
    input  wire                             presetn,
    input  wire apb3_mon_pkg::apb_bus_t     cur,
    input  wire apb3_mon_pkg::apb_bus_t     prev,
    input  wire apb3_mon_pkg::apb_phase_e   cur_phase,
    input  wire apb3_mon_pkg::apb_phase_e   prev_phase,
    input  wire [`APB3_WAIT_CNT_W-1:0]      wait_cnt,
    output apb3_mon_pkg::rule_mask_t        rule_hit,
    output logic                            done_valid,
    output apb3_mon_pkg::apb_xfer_t         done_xfer
);

    import apb3_mon_pkg::*;

    rule_mask_t hit;
    logic       ctrl_moved;
    logic       prev_waiting;
    logic       done;
    slave_idx_t slave_idx;
    apb_xfer_t  xfer_d;

    // Select, address and direction moved since the last sample
    // Write data only matters when the held transfer is a write
    assign ctrl_moved = (cur.psel != prev.psel) ||
                        (cur.paddr != prev.paddr) ||
                        (cur.pwrite != prev.pwrite) ||
                        (prev.pwrite && (cur.pwdata != prev.pwdata));

    // Previous cycle was a wait state
    assign prev_waiting = (prev_phase == ACCESS) && !prev.pready;

    // Transfer ends on ACCESS with PREADY high
    assign done = (cur_phase == ACCESS) && cur.pready;

    always_comb begin
        hit = '0;
        // PENABLE without any select
        hit[RULE_PENABLE_NO_PSEL]  = (cur_phase == ERROR);
        // Skipped SETUP
        hit[RULE_IDLE_TO_ACCESS]   = (prev_phase == IDLE) && (cur_phase == ACCESS);
        // SETUP lasts exactly one cycle
        hit[RULE_SETUP_NOT_ACCESS] = (prev_phase == SETUP) && (cur_phase != ACCESS);
        // Only judged when ACCESS did follow, else the rule above covers it
        hit[RULE_SETUP_UNSTABLE]   = (prev_phase == SETUP) && (cur_phase == ACCESS) &&
                                     ctrl_moved;
        // Wait state must hold everything, PENABLE included
        hit[RULE_WAIT_UNSTABLE]    = prev_waiting && (ctrl_moved || !cur.penable);
        // Still low after APB3_MAX_WAIT earlier wait cycles
        hit[RULE_WAIT_TIMEOUT]     = (cur_phase == ACCESS) && !cur.pready &&
                                     (wait_cnt == `APB3_MAX_WAIT);
        // PSLVERR only sampled on the completing ACCESS cycle
        hit[RULE_SLVERR_UNSAMPLED] = cur.pslverr && !done;
        // Clearing the lowest set bit leaves something when two are set
        hit[RULE_MULTI_SEL]        = (cur.psel & (cur.psel - 1'b1)) != '0;
    end

    // One-hot PSEL to index, highest set bit wins if the rule above fired
    always_comb begin
        slave_idx = '0;
        for (int i = 0; i < `APB3_PSEL_N; i++) begin
            if (cur.psel[i]) begin
                slave_idx = slave_idx_t'(i);
            end
        end
    end

    always_comb begin
        xfer_d.slave  = slave_idx;
        xfer_d.addr   = cur.paddr;
        xfer_d.write  = cur.pwrite;
        xfer_d.data   = cur.pwrite ? cur.pwdata : cur.prdata;
        xfer_d.slverr = cur.pslverr;
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            rule_hit   <= '0;
            done_valid <= 1'b0;
        end else begin
            rule_hit   <= hit;
            done_valid <= done;
        end
    end

    // Record only loads on completion
    always_ff @(posedge pclk) begin
        if (done) begin
            done_xfer <= xfer_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/apb_xfer_reporter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apb3_mon_cfg.svh"

module apb_xfer_reporter (
    input  wire                             pclk,
    input  wire                             presetn,
    input  wire apb3_mon_pkg::rule_mask_t   rule_hit,
    input  wire                             done_valid,
    input  wire apb3_mon_pkg::apb_xfer_t    done_xfer,
    output logic                            xfer_valid,
    output apb3_mon_pkg::apb_xfer_t         xfer,
    output logic                            viol_valid,
    output apb3_mon_pkg::rule_mask_t        viol_mask,
    output apb3_mon_pkg::rule_mask_t        sticky_mask,
    output apb3_mon_pkg::viol_cnt_t         viol_count
);

    import apb3_mon_pkg::*;

    logic any_hit;

    assign any_hit = |rule_hit;

    // Strobes and status
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            xfer_valid  <= 1'b0;
            viol_valid  <= 1'b0;
            viol_mask   <= '0;
            sticky_mask <= '0;
            viol_count  <= '0;
        end else begin
            xfer_valid  <= done_valid;
            viol_valid  <= any_hit;
            viol_mask   <= rule_hit;
            // Bits stay set until reset
            sticky_mask <= sticky_mask | rule_hit;
            // One count per cycle with any violation, held at all ones
            if (any_hit && (viol_count != '1)) begin
                viol_count <= viol_count + 1'b1;
            end
        end
    end

    // Transfer record, valid with xfer_valid
    always_ff @(posedge pclk) begin
        if (done_valid) begin
            xfer <= done_xfer;
        end
    end

endmodule

`default_nettype wire

// ==== design/apb3_protocol_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apb3_mon_cfg.svh"

module apb3_protocol_monitor (
    input  wire                             pclk,
    input  wire                             presetn,
    input  wire apb3_mon_pkg::apb_bus_t     bus,
    output logic                            xfer_valid,
    output apb3_mon_pkg::apb_xfer_t         xfer,
    output logic                            viol_valid,
    output apb3_mon_pkg::rule_mask_t        viol_mask,
    output apb3_mon_pkg::rule_mask_t        sticky_mask,
    output apb3_mon_pkg::viol_cnt_t         viol_count
);

    import apb3_mon_pkg::*;

    // Tracker to checker
    apb_bus_t                    cur;
    apb_bus_t                    prev;
    apb_phase_e                  cur_phase;
    apb_phase_e                  prev_phase;
    logic [`APB3_WAIT_CNT_W-1:0] wait_cnt;

    // Checker to reporter
    rule_mask_t                  rule_hit;
    logic                        done_valid;
    apb_xfer_t                   done_xfer;

    // Sample and classify
    apb_phase_tracker u_apb_phase_tracker (
        .pclk       (pclk),
        .presetn    (presetn),
        .bus        (bus),
        .cur        (cur),
        .prev       (prev),
        .cur_phase  (cur_phase),
        .prev_phase (prev_phase),
        .wait_cnt   (wait_cnt)
    );

    // Rules and transfer completion
    apb_rule_checker u_apb_rule_checker (
        .pclk       (pclk),
        .presetn    (presetn),
        .cur        (cur),
        .prev       (prev),
        .cur_phase  (cur_phase),
        .prev_phase (prev_phase),
        .wait_cnt   (wait_cnt),
        .rule_hit   (rule_hit),
        .done_valid (done_valid),
        .done_xfer  (done_xfer)
    );

    // Records, strobes and sticky status
    apb_xfer_reporter u_apb_xfer_reporter (
        .pclk        (pclk),
        .presetn     (presetn),
        .rule_hit    (rule_hit),
        .done_valid  (done_valid),
        .done_xfer   (done_xfer),
        .xfer_valid  (xfer_valid),
        .xfer        (xfer),
        .viol_valid  (viol_valid),
        .viol_mask   (viol_mask),
        .sticky_mask (sticky_mask),
        .viol_count  (viol_count)
    );

endmodule

`default_nettype wire

// ==== sim/apb3_protocol_monitor_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb3_protocol_monitor_assert (
    input  wire                             pclk,
    input  wire                             presetn,
    input  wire                             viol_valid,
    input  wire apb3_mon_pkg::rule_mask_t   viol_mask,
    input  wire apb3_mon_pkg::rule_mask_t   sticky_mask,
    input  wire apb3_mon_pkg::viol_cnt_t    viol_count
);

    import apb3_mon_pkg::*;

    // Number of assertion failures, read hierarchically at the end of the run
    int fail_count = 0;

    // Strobe is high exactly when some rule fired
    a_viol_valid: assert property (@(posedge pclk) disable iff (!presetn)
        viol_valid == (viol_mask != '0))
    else begin
        fail_count++;
        $error("viol_valid disagrees with viol_mask");
    end

    // Sticky bits only accumulate
    a_sticky_keep: assert property (@(posedge pclk) disable iff (!presetn)
        (sticky_mask & $past(sticky_mask)) == $past(sticky_mask))
    else begin
        fail_count++;
        $error("sticky_mask lost a bit");
    end

    // Saturating counter never steps back
    a_count_mono: assert property (@(posedge pclk) disable iff (!presetn)
        viol_count >= $past(viol_count))
    else begin
        fail_count++;
        $error("viol_count decreased");
    end

endmodule

// Attach to every reporter instance
bind apb_xfer_reporter apb3_protocol_monitor_assert u_reporter_assert (
    .pclk        (pclk),
    .presetn     (presetn),
    .viol_valid  (viol_valid),
    .viol_mask   (viol_mask),
    .sticky_mask (sticky_mask),
    .viol_count  (viol_count)
);

`default_nettype wire

// ==== sim/tb_apb3_protocol_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "apb3_mon_cfg.svh"

module tb_apb3_protocol_monitor;

    import apb3_mon_pkg::*;

    // Falling edges from driving a row to seeing its result
    localparam int LAT          = 3;
    localparam int RESET_CYCLES = 8;
    localparam int SETTLE_LIMIT = 20;
    localparam int DRAIN_LIMIT  = 10;

    // Single rule bits for the table
    localparam rule_mask_t NO_HIT = '0;
    localparam rule_mask_t H_PEN  = rule_mask_t'(1) << RULE_PENABLE_NO_PSEL;
    localparam rule_mask_t H_I2A  = rule_mask_t'(1) << RULE_IDLE_TO_ACCESS;
    localparam rule_mask_t H_SNA  = rule_mask_t'(1) << RULE_SETUP_NOT_ACCESS;
    localparam rule_mask_t H_SUN  = rule_mask_t'(1) << RULE_SETUP_UNSTABLE;
    localparam rule_mask_t H_WUN  = rule_mask_t'(1) << RULE_WAIT_UNSTABLE;
    localparam rule_mask_t H_TMO  = rule_mask_t'(1) << RULE_WAIT_TIMEOUT;
    localparam rule_mask_t H_SLV  = rule_mask_t'(1) << RULE_SLVERR_UNSAMPLED;
    localparam rule_mask_t H_MUL  = rule_mask_t'(1) << RULE_MULTI_SEL;

    // Draw new address and data, or keep the last ones
    localparam bit CHG = 1'b1;
    localparam bit HLD = 1'b0;

    // One bus cycle and its expected outcome
    typedef struct packed {
        logic [`APB3_PSEL_N-1:0] psel;
        logic                    penable;
        logic                    pwrite;
        logic                    pready;
        logic                    pslverr;
        logic                    fresh;
        rule_mask_t              mask;
        logic                    done;
    } row_t;

    logic                    pclk;
    logic                    presetn;
    apb_bus_t                bus;
    logic                    xfer_valid;
    apb_xfer_t               xfer;
    logic                    viol_valid;
    rule_mask_t              viol_mask;
    rule_mask_t              sticky_mask;
    viol_cnt_t               viol_count;

    row_t                    rows[$];
    apb_xfer_t               exp_xfer[$];
    logic [31:0]             rng;
    logic [`APB3_ADDR_W-1:0] addr_q;
    logic [`APB3_DATA_W-1:0] wdata_q;
    logic [`APB3_DATA_W-1:0] rdata_q;
    rule_mask_t              exp_sticky;
    viol_cnt_t               exp_count;

    apb3_protocol_monitor u_apb3_protocol_monitor (
        .pclk        (pclk),
        .presetn     (presetn),
        .bus         (bus),
        .xfer_valid  (xfer_valid),
        .xfer        (xfer),
        .viol_valid  (viol_valid),
        .viol_mask   (viol_mask),
        .sticky_mask (sticky_mask),
        .viol_count  (viol_count)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Position of the select bit, scanning down so the lowest set bit wins
    function automatic slave_idx_t sel_to_index(input logic [`APB3_PSEL_N-1:0] sel);
        slave_idx_t idx;
        idx = '0;
        for (int i = `APB3_PSEL_N - 1; i >= 0; i--) begin
            if (sel[i]) begin
                idx = slave_idx_t'(i);
            end
        end
        return idx;
    endfunction

    task automatic fail_stop();
        $display("Simulation FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_xfer(input string name, input apb_xfer_t exp, input apb_xfer_t act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_mask(input string name, input rule_mask_t exp, input rule_mask_t act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_count(input string name, input viol_cnt_t exp, input viol_cnt_t act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0t ns: %s expected %b actual %b", $time, name, exp, act);
            fail_stop();
        end
    endtask

    task automatic add_row(input logic [`APB3_PSEL_N-1:0] psel, input logic en,
                           input logic wr, input logic rdy, input logic err,
                           input logic fresh, input rule_mask_t mask, input logic done);
        row_t r;
        r.psel    = psel;
        r.penable = en;
        r.pwrite  = wr;
        r.pready  = rdy;
        r.pslverr = err;
        r.fresh   = fresh;
        r.mask    = mask;
        r.done    = done;
        rows.push_back(r);
    endtask

    // Columns are psel, penable, pwrite, pready, pslverr, data, mask, done
    task automatic build_table();
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // Write to slave 0 with no wait
        add_row(4'b0001, 0, 1, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0001, 1, 1, 1, 0, HLD, NO_HIT, 1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // Read from slave 2 with two waits
        add_row(4'b0100, 0, 0, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0100, 1, 0, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0100, 1, 0, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0100, 1, 0, 1, 0, HLD, NO_HIT, 1);
        // Back to back write to slave 3 with two waits
        add_row(4'b1000, 0, 1, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b1000, 1, 1, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b1000, 1, 1, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b1000, 1, 1, 1, 0, HLD, NO_HIT, 1);
        // Read from slave 1 ending with a sampled PSLVERR
        add_row(4'b0010, 0, 0, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0010, 1, 0, 1, 1, HLD, NO_HIT, 1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // PENABLE alone
        add_row(4'b0000, 1, 0, 0, 0, HLD, H_PEN,  0);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // ACCESS straight from IDLE still completes
        add_row(4'b0001, 1, 0, 1, 0, CHG, H_I2A,  1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // SETUP abandoned
        add_row(4'b0010, 0, 0, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0000, 0, 0, 0, 0, HLD, H_SNA,  0);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // New address and data on entering ACCESS
        add_row(4'b0001, 0, 1, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0001, 1, 1, 1, 0, CHG, H_SUN,  1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // New address and data inside a wait
        add_row(4'b0100, 0, 1, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0100, 1, 1, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0100, 1, 1, 0, 0, CHG, H_WUN,  0);
        add_row(4'b0100, 1, 1, 1, 0, HLD, NO_HIT, 1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // Fourth wait cycle trips the limit
        add_row(4'b0010, 0, 0, 0, 0, CHG, NO_HIT, 0);
        add_row(4'b0010, 1, 0, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0010, 1, 0, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0010, 1, 0, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0010, 1, 0, 0, 0, HLD, H_TMO,  0);
        add_row(4'b0010, 1, 0, 1, 0, HLD, NO_HIT, 1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // PSLVERR in SETUP
        add_row(4'b1000, 0, 0, 0, 1, CHG, H_SLV,  0);
        add_row(4'b1000, 1, 0, 1, 0, HLD, NO_HIT, 1);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        // Two selects, then dropped
        add_row(4'b0011, 0, 1, 0, 0, CHG, H_MUL,  0);
        add_row(4'b0000, 0, 0, 0, 0, HLD, H_SNA,  0);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
        add_row(4'b0000, 0, 0, 0, 0, HLD, NO_HIT, 0);
    endtask

    // Put one row on the bus and note the record it would produce
    task automatic drive_row(input int idx);
        row_t      r;
        apb_bus_t  b;
        apb_xfer_t x;
        r = rows[idx];
        if (r.fresh) begin
            rng     = xorshift32(rng);
            addr_q  = rng[`APB3_ADDR_W-1:0];
            rng     = xorshift32(rng);
            wdata_q = rng;
            rng     = xorshift32(rng);
            rdata_q = rng;
        end
        b.psel    = r.psel;
        b.penable = r.penable;
        b.paddr   = addr_q;
        b.pwrite  = r.pwrite;
        b.pwdata  = wdata_q;
        b.pready  = r.pready;
        b.prdata  = rdata_q;
        b.pslverr = r.pslverr;
        bus       = b;
        x.slave   = sel_to_index(r.psel);
        x.addr    = addr_q;
        x.write   = r.pwrite;
        x.data    = r.pwrite ? wdata_q : rdata_q;
        x.slverr  = r.pslverr;
        exp_xfer.push_back(x);
    endtask

    // Outputs for a row driven LAT falling edges ago
    task automatic check_row(input int idx);
        row_t r;
        r = rows[idx];
        exp_sticky = exp_sticky | r.mask;
        if (r.mask != '0 && exp_count != '1) begin
            exp_count = exp_count + 1'b1;
        end
        check_mask("viol_mask", r.mask, viol_mask);
        check_flag("viol_valid", r.mask != '0, viol_valid);
        check_mask("sticky_mask", exp_sticky, sticky_mask);
        check_count("viol_count", exp_count, viol_count);
        check_flag("xfer_valid", r.done, xfer_valid);
        if (r.done) begin
            check_xfer("xfer", exp_xfer[idx], xfer);
        end
    endtask

    task automatic wait_clear();
        int cycles;
        cycles = 0;
        @(negedge pclk);
        while (!(xfer_valid === 1'b0 && viol_valid === 1'b0 &&
                 sticky_mask === '0 && viol_count === '0)) begin
            @(negedge pclk);
            cycles++;
            if (cycles > SETTLE_LIMIT) begin
                $display("Timeout: monitor status did not clear after reset");
                fail_stop();
            end
        end
    endtask

    initial begin
        int         checked;
        int         guard;
        rule_mask_t all_mask;
        viol_cnt_t  nz_rows;
        rng        = 32'hf500_2f60;
        addr_q     = '0;
        wdata_q    = '0;
        rdata_q    = '0;
        exp_sticky = '0;
        exp_count  = '0;
        bus        = '0;
        presetn    = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(negedge pclk);
        presetn = 1'b1;
        wait_clear();
        // Check the row from LAT edges back, then drive the next one
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge pclk);
            if (i >= LAT) begin
                check_row(i - LAT);
            end
            drive_row(i);
        end
        // Idle bus while the last rows come out
        checked = rows.size() - LAT;
        guard   = 0;
        while (checked < rows.size()) begin
            @(negedge pclk);
            bus = '0;
            check_row(checked);
            checked++;
            guard++;
            if (guard > DRAIN_LIMIT) begin
                $display("Timeout: results for the last rows never arrived");
                fail_stop();
            end
        end
        // Totals over the whole table
        all_mask = '0;
        nz_rows  = '0;
        foreach (rows[k]) begin
            all_mask = all_mask | rows[k].mask;
            if (rows[k].mask != '0) begin
                nz_rows = nz_rows + 1'b1;
            end
        end
        check_mask("sticky_mask", all_mask, sticky_mask);
        check_count("viol_count", nz_rows, viol_count);
        if (u_apb3_protocol_monitor.u_apb_xfer_reporter.u_reporter_assert.fail_count != 0) begin
            $display("Bound assertions on the reporter failed during the run");
            fail_stop();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
design/apb3_mon_pkg.sv
design/apb_phase_tracker.sv
design/apb_rule_checker.sv
design/apb_xfer_reporter.sv
design/apb3_protocol_monitor.sv
sim/apb3_protocol_monitor_assert.sv
sim/tb_apb3_protocol_monitor.sv
